//--- hw/mem_stage_pkg.sv
// Shared sizes, opcode encodings, control register map and instruction layout of the memory stage
package mem_stage_pkg;

	// Vector register geometry
	localparam int VECTOR_LANES = 4;
	localparam int VECTOR_BITS = VECTOR_LANES * 32;

	// Line geometry of the on-chip line memory
	localparam int LINE_WORDS = 4;
	localparam int LINE_BYTES = LINE_WORDS * 4;
	localparam int LINE_BITS = LINE_BYTES * 8;

	localparam int STRAND_INDEX_WIDTH = 2;
	localparam int REG_IDX_WIDTH = 5;

	// Line memory depth, indexed by address bits 7:4
	localparam int MEM_LINES = 16;
	localparam int IO_WORDS = 4;

	// Word that replaces a squashed instruction
	localparam logic [31:0] NOP = 32'h0000_0000;

	// Instruction class codes in the top bits of the word
	localparam logic [1:0] FMTC_CLASS = 2'b10;
	localparam logic [3:0] FMTD_CLASS = 4'b1110;

	typedef enum logic [3:0] {
		MEM_B,
		MEM_BX,
		MEM_S,
		MEM_SX,
		MEM_L,
		MEM_SYNC,
		MEM_CONTROL_REG,
		MEM_BLOCK,
		MEM_BLOCK_M,
		MEM_SCGATH,
		MEM_SCGATH_M
	} fmtc_op_t;

	typedef enum logic [2:0] {
		CACHE_DFLUSH,
		CACHE_STBAR,
		CACHE_DINVALIDATE,
		CACHE_IINVALIDATE
	} fmtd_op_t;

	typedef enum logic [4:0] {
		CR_STRAND_ID = 5'd0,
		CR_FAULT_COUNT = 5'd1,
		CR_SCRATCH0 = 5'd8,
		CR_SCRATCH1 = 5'd9,
		CR_SCRATCH2 = 5'd10,
		CR_SCRATCH3 = 5'd11
	} control_register_t;

	// One instruction word seen either as a memory access or as a cache operation
	typedef union packed {
		struct packed {
			logic [1:0] fmt_class;
			logic load;
			fmtc_op_t op;
			logic [24:0] rest;
		} fmtc;
		struct packed {
			logic [3:0] fmt_class;
			fmtd_op_t op;
			logic [24:0] rest;
		} fmtd;
	} instruction_t;

endpackage

//--- hw/dcache_req_if.sv
// Line-memory request bundle between the memory access stage and the line memory
`timescale 1ns/100ps

interface dcache_req_if
	import mem_stage_pkg::*;
	();

	// Line address, byte offset bits dropped
	logic [31 - $clog2(LINE_BYTES):0] addr;
	logic load;
	logic store;
	logic [LINE_BYTES - 1:0] store_mask;
	logic [LINE_BITS - 1:0] store_data;

	modport stage (
		output addr,
		output load,
		output store,
		output store_mask,
		output store_data
	);

	modport mem (
		input addr,
		input load,
		input store,
		input store_mask,
		input store_data
	);

endinterface

//--- hw/memory_access_stage.sv
// Memory access stage that decodes memory instructions, issues line, IO and CR requests
`timescale 1ns/100ps

module memory_access_stage
	import mem_stage_pkg::*;
	(
	input logic clk,
	input logic reset,
	input logic rb_squash_ma,
	input instruction_t ex_instruction,
	input logic [STRAND_INDEX_WIDTH - 1:0] ex_strand,
	input logic [VECTOR_BITS - 1:0] ex_store_value,
	input logic [REG_IDX_WIDTH - 1:0] ex_writeback_reg,
	input logic ex_enable_scalar_writeback,
	input logic ex_enable_vector_writeback,
	input logic [31:0] ex_pc,
	input logic [VECTOR_LANES - 1:0] ex_mask,
	input logic [VECTOR_BITS - 1:0] ex_result,
	input logic [$clog2(VECTOR_LANES) - 1:0] ex_reg_lane_select,
	input logic [31:0] cr_read_value,
	input logic [31:0] io_read_data,
	output logic [STRAND_INDEX_WIDTH - 1:0] ma_strand,
	output instruction_t ma_instruction,
	output logic [31:0] ma_pc,
	output logic [REG_IDX_WIDTH - 1:0] ma_writeback_reg,
	output logic ma_enable_scalar_writeback,
	output logic ma_enable_vector_writeback,
	output logic [VECTOR_LANES - 1:0] ma_mask,
	output logic [VECTOR_BITS - 1:0] ma_result,
	output logic [$clog2(VECTOR_LANES) - 1:0] ma_reg_lane_select,
	output logic [$clog2(LINE_WORDS) - 1:0] ma_cache_lane_select,
	output logic ma_was_load,
	output logic ma_alignment_fault,
	output logic ma_was_io,
	output logic [31:0] ma_io_response,
	output control_register_t cr_index,
	output logic cr_read_en,
	output logic cr_write_en,
	output logic [31:0] cr_write_value,
	output logic io_read_en,
	output logic io_write_en,
	output logic [31:0] io_address,
	output logic [31:0] io_write_data,
	output logic dcache_req_sync,
	output logic cache_flush,
	output logic cache_stbar,
	output logic cache_dinvalidate,
	output logic cache_iinvalidate,
	dcache_req_if.stage dcache
	);

	fmtc_op_t fmtc_op;
	fmtd_op_t fmtd_op;
	logic is_fmt_c;
	logic is_fmt_d;
	logic is_load;
	logic is_cr_transfer;
	logic is_block;
	logic is_scgath;
	logic lane_enabled;
	logic unaligned;
	logic bad_io;
	logic is_io_address;
	logic do_access;
	logic bad_access;
	logic [31:0] lane_value;
	logic [31:0] mem_addr;
	logic [$clog2(LINE_WORDS) - 1:0] cache_lane_select_nxt;
	logic [LINE_WORDS - 1:0] word_mask;
	logic [3:0] byte_mask;
	logic [31:0] word_data;
	logic [LINE_BITS - 1:0] block_data;
	logic [LINE_BYTES - 1:0] store_mask;

	// Registers hold little-endian values, memory is big-endian
	function automatic logic [31:0] swap_bytes(input logic [31:0] value);
		return {value[7:0], value[15:8], value[23:16], value[31:24]};
	endfunction

	assign is_fmt_c = ex_instruction.fmtc.fmt_class == FMTC_CLASS;
	assign is_fmt_d = ex_instruction.fmtd.fmt_class == FMTD_CLASS;
	assign is_load = ex_instruction.fmtc.load;
	assign fmtc_op = ex_instruction.fmtc.op;
	assign fmtd_op = ex_instruction.fmtd.op;

	assign is_cr_transfer = is_fmt_c && fmtc_op == MEM_CONTROL_REG;
	assign is_block = fmtc_op == MEM_BLOCK || fmtc_op == MEM_BLOCK_M;
	assign is_scgath = fmtc_op == MEM_SCGATH || fmtc_op == MEM_SCGATH_M;
	assign lane_enabled = is_block ? ex_mask != '0 : ex_mask[ex_reg_lane_select];

	// Scatter/gather takes its pointer from the selected lane
	assign lane_value = ex_store_value[32 * ex_reg_lane_select +: 32];
	assign mem_addr = is_scgath ? ex_result[32 * ex_reg_lane_select +: 32] : ex_result[31:0];
	assign cache_lane_select_nxt = mem_addr[$clog2(LINE_BYTES) - 1:2];
	assign is_io_address = &mem_addr[31:16];
	assign bad_io = is_io_address && fmtc_op != MEM_L;

	assign do_access = is_fmt_c && !is_cr_transfer && !rb_squash_ma && lane_enabled
		&& !unaligned && !bad_io;
	assign bad_access = is_fmt_c && !is_cr_transfer && !rb_squash_ma && (unaligned || bad_io);

	assign dcache.addr = mem_addr[31:$clog2(LINE_BYTES)];
	assign dcache.load = do_access && is_load && !is_io_address;
	assign dcache.store = do_access && !is_load && !is_io_address;
	assign dcache.store_mask = store_mask;
	assign dcache.store_data = is_block ? block_data : {LINE_WORDS{word_data}};
	assign dcache_req_sync = is_fmt_c && fmtc_op == MEM_SYNC;

	assign io_read_en = do_access && is_load && is_io_address;
	assign io_write_en = do_access && !is_load && is_io_address;
	assign io_address = {16'h0000, mem_addr[15:0]};
	assign io_write_data = ex_store_value[31:0];

	assign cache_flush = is_fmt_d && fmtd_op == CACHE_DFLUSH && !rb_squash_ma;
	assign cache_stbar = is_fmt_d && fmtd_op == CACHE_STBAR && !rb_squash_ma;
	assign cache_dinvalidate = is_fmt_d && fmtd_op == CACHE_DINVALIDATE && !rb_squash_ma;
	assign cache_iinvalidate = is_fmt_d && fmtd_op == CACHE_IINVALIDATE && !rb_squash_ma;

	// CR reads go ahead even under squash
	assign cr_index = control_register_t'(ex_instruction.fmtc.rest[4:0]);
	assign cr_read_en = is_cr_transfer && is_load;
	assign cr_write_en = is_cr_transfer && !is_load && !rb_squash_ma;
	assign cr_write_value = ex_store_value[31:0];

	always_comb
	begin
		unique case (fmtc_op)
			MEM_B, MEM_BX:
				unaligned = 1'b0;
			MEM_S, MEM_SX:
				unaligned = mem_addr[0];
			MEM_L, MEM_SYNC, MEM_SCGATH, MEM_SCGATH_M:
				unaligned = mem_addr[1:0] != 2'b00;
			default:
				unaligned = mem_addr[$clog2(LINE_BYTES) - 1:0] != '0;
		endcase
	end

	// Byte lanes within a word and the word pattern replicated across the line
	always_comb
	begin
		unique case (fmtc_op)
			MEM_B, MEM_BX:
			begin
				byte_mask = 4'b1000 >> mem_addr[1:0];
				word_data = {4{ex_store_value[7:0]}};
			end
			MEM_S, MEM_SX:
			begin
				byte_mask = mem_addr[1] ? 4'b0011 : 4'b1100;
				word_data = {2{ex_store_value[7:0], ex_store_value[15:8]}};
			end
			MEM_SCGATH, MEM_SCGATH_M:
			begin
				byte_mask = 4'b1111;
				word_data = swap_bytes(lane_value);
			end
			default:
			begin
				byte_mask = 4'b1111;
				word_data = swap_bytes(ex_store_value[31:0]);
			end
		endcase
	end

	// Lane k lands in line word LINE_WORDS-1-k
	always_comb
	begin
		if (is_block)
			word_mask = ex_mask;
		else
			word_mask = LINE_WORDS'(1) << (LINE_WORDS - 1 - cache_lane_select_nxt);
	end

	always_comb
	begin
		for (int k = 0; k < VECTOR_LANES; k++)
			block_data[32 * k +: 32] = swap_bytes(ex_store_value[32 * k +: 32]);
	end

	always_comb
	begin
		for (int i = 0; i < LINE_BYTES; i++)
			store_mask[i] = word_mask[i / 4] & byte_mask[i % 4];
	end

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			ma_instruction <= '0;
			ma_enable_scalar_writeback <= 1'b0;
			ma_enable_vector_writeback <= 1'b0;
			ma_alignment_fault <= 1'b0;
			ma_was_load <= 1'b0;
			ma_was_io <= 1'b0;
		end
		else
		begin
			ma_was_load <= dcache.load;
			ma_was_io <= io_read_en || io_write_en;
			ma_alignment_fault <= bad_access;
			if (rb_squash_ma)
			begin
				ma_instruction <= NOP;
				ma_enable_scalar_writeback <= 1'b0;
				ma_enable_vector_writeback <= 1'b0;
			end
			else
			begin
				ma_instruction <= ex_instruction;
				ma_enable_scalar_writeback <= ex_enable_scalar_writeback;
				ma_enable_vector_writeback <= ex_enable_vector_writeback;
			end
		end
	end

	// Writeback payload
	always_ff @(posedge clk)
	begin
		ma_strand <= ex_strand;
		ma_pc <= ex_pc;
		ma_writeback_reg <= ex_writeback_reg;
		ma_mask <= ex_mask;
		ma_result <= cr_read_en ? {{(VECTOR_BITS - 32){1'b0}}, cr_read_value} : ex_result;
		ma_reg_lane_select <= ex_reg_lane_select;
		ma_cache_lane_select <= cache_lane_select_nxt;
		ma_io_response <= io_read_data;
	end

endmodule

//--- hw/control_regs.sv
// Control register bank with scratch registers, a fault counter and the strand ID view
`timescale 1ns/100ps

module control_regs
	import mem_stage_pkg::*;
	(
	input logic clk,
	input logic reset,
	input control_register_t cr_index,
	input logic cr_read_en,
	input logic cr_write_en,
	input logic [31:0] cr_write_value,
	input logic [STRAND_INDEX_WIDTH - 1:0] cr_strand,
	input logic fault_seen,
	output logic [31:0] cr_read_value
	);

	logic [31:0] scratch [CR_SCRATCH3 - CR_SCRATCH0 + 1];
	logic [31:0] fault_count;
	logic is_scratch;
	logic [1:0] scratch_sel;

	assign is_scratch = cr_index >= CR_SCRATCH0 && cr_index <= CR_SCRATCH3;
	assign scratch_sel = 2'(cr_index - CR_SCRATCH0);

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i <= CR_SCRATCH3 - CR_SCRATCH0; i++)
				scratch[i] <= '0;
			fault_count <= '0;
		end
		else
		begin
			if (cr_write_en && is_scratch)
				scratch[scratch_sel] <= cr_write_value;
			// One count per cycle with a reported fault
			if (fault_seen)
				fault_count <= fault_count + 32'd1;
		end
	end

	always_comb
	begin
		if (!cr_read_en)
			cr_read_value = '0;
		else if (cr_index == CR_STRAND_ID)
			cr_read_value = 32'(cr_strand);
		else if (cr_index == CR_FAULT_COUNT)
			cr_read_value = fault_count;
		else if (is_scratch)
			cr_read_value = scratch[scratch_sel];
		else
			cr_read_value = '0;
	end

endmodule

//--- hw/line_memory.sv
// Byte-maskable line memory that answers every access, with a registered line read
`timescale 1ns/100ps

module line_memory
	import mem_stage_pkg::*;
	(
	input logic clk,
	input logic reset,
	dcache_req_if.mem req,
	output logic [LINE_BITS - 1:0] read_line
	);

	logic [LINE_BITS - 1:0] lines [MEM_LINES];
	logic [$clog2(MEM_LINES) - 1:0] line_idx;

	// Upper address bits alias onto the same lines
	assign line_idx = req.addr[$clog2(MEM_LINES) - 1:0];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < MEM_LINES; i++)
				lines[i] <= '0;
		end
		else if (req.store)
		begin
			for (int b = 0; b < LINE_BYTES; b++)
			begin
				if (req.store_mask[b])
					lines[line_idx][8 * b +: 8] <= req.store_data[8 * b +: 8];
			end
		end
	end

	// Read line lines up with ma_was_load one cycle later
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			read_line <= '0;
		else if (req.load)
			read_line <= lines[line_idx];
	end

endmodule

//--- hw/io_scratch.sv
// Memory-mapped IO device of word registers, written on a strobe and read combinationally
`timescale 1ns/100ps

module io_scratch
	import mem_stage_pkg::*;
	(
	input logic clk,
	input logic reset,
	input logic io_read_en,
	input logic io_write_en,
	input logic [31:0] io_address,
	input logic [31:0] io_write_data,
	output logic [31:0] io_read_data
	);

	logic [31:0] regs [IO_WORDS];
	logic [$clog2(IO_WORDS) - 1:0] reg_sel;

	// Word registers at consecutive word addresses
	assign reg_sel = io_address[$clog2(IO_WORDS) + 1:2];

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < IO_WORDS; i++)
				regs[i] <= '0;
		end
		else if (io_write_en)
			regs[reg_sel] <= io_write_data;
	end

	assign io_read_data = io_read_en ? regs[reg_sel] : 32'h0000_0000;

endmodule

//--- hw/memory_subsystem_top.sv
// Memory subsystem top joining the access stage, control registers, line memory and IO device
`timescale 1ns/100ps

module memory_subsystem_top
	import mem_stage_pkg::*;
	(
	input logic clk,
	input logic reset,
	input logic rb_squash_ma,
	input instruction_t ex_instruction,
	input logic [STRAND_INDEX_WIDTH - 1:0] ex_strand,
	input logic [VECTOR_BITS - 1:0] ex_store_value,
	input logic [REG_IDX_WIDTH - 1:0] ex_writeback_reg,
	input logic ex_enable_scalar_writeback,
	input logic ex_enable_vector_writeback,
	input logic [31:0] ex_pc,
	input logic [VECTOR_LANES - 1:0] ex_mask,
	input logic [VECTOR_BITS - 1:0] ex_result,
	input logic [$clog2(VECTOR_LANES) - 1:0] ex_reg_lane_select,
	output logic [STRAND_INDEX_WIDTH - 1:0] ma_strand,
	output instruction_t ma_instruction,
	output logic [31:0] ma_pc,
	output logic [REG_IDX_WIDTH - 1:0] ma_writeback_reg,
	output logic ma_enable_scalar_writeback,
	output logic ma_enable_vector_writeback,
	output logic [VECTOR_LANES - 1:0] ma_mask,
	output logic [VECTOR_BITS - 1:0] ma_result,
	output logic [$clog2(VECTOR_LANES) - 1:0] ma_reg_lane_select,
	output logic [$clog2(LINE_WORDS) - 1:0] ma_cache_lane_select,
	output logic ma_was_load,
	output logic ma_alignment_fault,
	output logic ma_was_io,
	output logic [31:0] ma_io_response,
	output logic [LINE_BITS - 1:0] load_line,
	output logic dcache_req_sync,
	output logic cache_flush,
	output logic cache_stbar,
	output logic cache_dinvalidate,
	output logic cache_iinvalidate
	);

	control_register_t cr_index;
	logic cr_read_en;
	logic cr_write_en;
	logic [31:0] cr_write_value;
	logic [31:0] cr_read_value;
	logic io_read_en;
	logic io_write_en;
	logic [31:0] io_address;
	logic [31:0] io_write_data;
	logic [31:0] io_read_data;

	dcache_req_if dcache_req();

	memory_access_stage i_memory_access_stage (
		.clk(clk), .reset(reset), .rb_squash_ma(rb_squash_ma),
		.ex_instruction(ex_instruction), .ex_strand(ex_strand),
		.ex_store_value(ex_store_value), .ex_writeback_reg(ex_writeback_reg),
		.ex_enable_scalar_writeback(ex_enable_scalar_writeback),
		.ex_enable_vector_writeback(ex_enable_vector_writeback),
		.ex_pc(ex_pc), .ex_mask(ex_mask), .ex_result(ex_result),
		.ex_reg_lane_select(ex_reg_lane_select),
		.cr_read_value(cr_read_value), .io_read_data(io_read_data),
		.ma_strand(ma_strand), .ma_instruction(ma_instruction), .ma_pc(ma_pc),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_enable_scalar_writeback(ma_enable_scalar_writeback),
		.ma_enable_vector_writeback(ma_enable_vector_writeback),
		.ma_mask(ma_mask), .ma_result(ma_result),
		.ma_reg_lane_select(ma_reg_lane_select),
		.ma_cache_lane_select(ma_cache_lane_select),
		.ma_was_load(ma_was_load), .ma_alignment_fault(ma_alignment_fault),
		.ma_was_io(ma_was_io), .ma_io_response(ma_io_response),
		.cr_index(cr_index), .cr_read_en(cr_read_en), .cr_write_en(cr_write_en),
		.cr_write_value(cr_write_value),
		.io_read_en(io_read_en), .io_write_en(io_write_en),
		.io_address(io_address), .io_write_data(io_write_data),
		.dcache_req_sync(dcache_req_sync), .cache_flush(cache_flush),
		.cache_stbar(cache_stbar), .cache_dinvalidate(cache_dinvalidate),
		.cache_iinvalidate(cache_iinvalidate),
		.dcache(dcache_req.stage)
	);

	// Fault counter watches the registered fault flag
	control_regs i_control_regs (
		.clk(clk), .reset(reset), .cr_index(cr_index),
		.cr_read_en(cr_read_en), .cr_write_en(cr_write_en),
		.cr_write_value(cr_write_value), .cr_strand(ex_strand),
		.fault_seen(ma_alignment_fault), .cr_read_value(cr_read_value)
	);

	line_memory i_line_memory (
		.clk(clk), .reset(reset), .req(dcache_req.mem), .read_line(load_line)
	);

	io_scratch i_io_scratch (
		.clk(clk), .reset(reset), .io_read_en(io_read_en), .io_write_en(io_write_en),
		.io_address(io_address), .io_write_data(io_write_data),
		.io_read_data(io_read_data)
	);

endmodule

//--- tb/tb_clock.sv
// Testbench clock source that toggles a free-running clock with a 4 ns period
`timescale 1ns/100ps

module tb_clock
	#(
	parameter real PERIOD_NS = 4.0
	)
	(
	output logic clk
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(PERIOD_NS / 2.0) clk = ~clk;
	end

endmodule

//--- tb/memory_subsystem_tb.sv
// Directed testbench for the memory subsystem against a byte-level big-endian line model
`timescale 1ns/100ps

module memory_subsystem_tb
	import mem_stage_pkg::*;
	();

	localparam int CLK_PERIOD_NS = 4;
	localparam int TEST_CYCLES = 80;
	localparam int MARGIN_NS = 200;

	logic clk;
	logic reset;
	logic rb_squash_ma;
	instruction_t ex_instruction;
	logic [STRAND_INDEX_WIDTH - 1:0] ex_strand;
	logic [VECTOR_BITS - 1:0] ex_store_value;
	logic [REG_IDX_WIDTH - 1:0] ex_writeback_reg;
	logic ex_enable_scalar_writeback;
	logic ex_enable_vector_writeback;
	logic [31:0] ex_pc;
	logic [VECTOR_LANES - 1:0] ex_mask;
	logic [VECTOR_BITS - 1:0] ex_result;
	logic [1:0] ex_reg_lane_select;
	logic [STRAND_INDEX_WIDTH - 1:0] ma_strand;
	instruction_t ma_instruction;
	logic [31:0] ma_pc;
	logic [REG_IDX_WIDTH - 1:0] ma_writeback_reg;
	logic ma_enable_scalar_writeback;
	logic ma_enable_vector_writeback;
	logic [VECTOR_LANES - 1:0] ma_mask;
	logic [VECTOR_BITS - 1:0] ma_result;
	logic [1:0] ma_reg_lane_select;
	logic [1:0] ma_cache_lane_select;
	logic ma_was_load;
	logic ma_alignment_fault;
	logic ma_was_io;
	logic [31:0] ma_io_response;
	logic [LINE_BITS - 1:0] load_line;
	logic dcache_req_sync;
	logic cache_flush;
	logic cache_stbar;
	logic cache_dinvalidate;
	logic cache_iinvalidate;

	integer seed;
	int error_count;
	int onehot_errors;
	int faults_expected;
	logic [STRAND_INDEX_WIDTH - 1:0] strand_sel;
	// Byte 0 of each line is its lowest address
	logic [7:0] mem_model [MEM_LINES][LINE_BYTES];

	tb_clock i_tb_clock (.clk(clk));

	memory_subsystem_top i_memory_subsystem_top (
		.clk(clk), .reset(reset), .rb_squash_ma(rb_squash_ma),
		.ex_instruction(ex_instruction), .ex_strand(ex_strand),
		.ex_store_value(ex_store_value), .ex_writeback_reg(ex_writeback_reg),
		.ex_enable_scalar_writeback(ex_enable_scalar_writeback),
		.ex_enable_vector_writeback(ex_enable_vector_writeback),
		.ex_pc(ex_pc), .ex_mask(ex_mask), .ex_result(ex_result),
		.ex_reg_lane_select(ex_reg_lane_select),
		.ma_strand(ma_strand), .ma_instruction(ma_instruction), .ma_pc(ma_pc),
		.ma_writeback_reg(ma_writeback_reg),
		.ma_enable_scalar_writeback(ma_enable_scalar_writeback),
		.ma_enable_vector_writeback(ma_enable_vector_writeback),
		.ma_mask(ma_mask), .ma_result(ma_result),
		.ma_reg_lane_select(ma_reg_lane_select),
		.ma_cache_lane_select(ma_cache_lane_select),
		.ma_was_load(ma_was_load), .ma_alignment_fault(ma_alignment_fault),
		.ma_was_io(ma_was_io), .ma_io_response(ma_io_response),
		.load_line(load_line), .dcache_req_sync(dcache_req_sync),
		.cache_flush(cache_flush), .cache_stbar(cache_stbar),
		.cache_dinvalidate(cache_dinvalidate), .cache_iinvalidate(cache_iinvalidate)
	);

	task automatic compare_line(input string name, input logic [LINE_BITS - 1:0] got,
		input logic [LINE_BITS - 1:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	task automatic compare_instruction(input string name, input instruction_t got,
		input instruction_t exp);
		if (got !== exp)
		begin
			$display("FAIL %s got %h expected %h", name, got, exp);
			error_count++;
		end
	endtask

	function automatic instruction_t mem_op(input logic load, input fmtc_op_t op,
		input logic [24:0] rest);
		instruction_t instr;
		instr.fmtc.fmt_class = FMTC_CLASS;
		instr.fmtc.load = load;
		instr.fmtc.op = op;
		instr.fmtc.rest = rest;
		return instr;
	endfunction

	function automatic instruction_t cache_op(input fmtd_op_t op);
		instruction_t instr;
		instr.fmtd.fmt_class = FMTD_CLASS;
		instr.fmtd.op = op;
		instr.fmtd.rest = '0;
		return instr;
	endfunction

	function automatic logic [VECTOR_BITS - 1:0] random_vector();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	// Big-endian line: the lowest address holds the most significant byte
	function automatic logic [LINE_BITS - 1:0] expected_line(input logic [3:0] idx);
		logic [LINE_BITS - 1:0] line;
		for (int o = 0; o < LINE_BYTES; o++)
			line[LINE_BITS - 1 - 8 * o -: 8] = mem_model[idx][o];
		return line;
	endfunction

	// Register byte j lands at address addr+j
	task automatic model_store(input logic [31:0] addr, input logic [31:0] value, input int nbytes);
		for (int j = 0; j < nbytes; j++)
			mem_model[addr[7:4]][addr[3:0] + j] = value[8 * j +: 8];
	endtask

	// Vector lane k occupies word LINE_WORDS-1-k of the line
	task automatic model_block_store(input logic [31:0] base, input logic [VECTOR_BITS - 1:0] value,
		input logic [3:0] mask);
		for (int k = 0; k < VECTOR_LANES; k++)
		begin
			if (mask[k])
				model_store(base + 32'(4 * (LINE_WORDS - 1 - k)), value[32 * k +: 32], 4);
		end
	endtask

	task automatic issue(input instruction_t instr, input logic [VECTOR_BITS - 1:0] result,
		input logic [VECTOR_BITS - 1:0] value, input logic [3:0] mask, input logic [1:0] lane,
		input logic squash);
		@(posedge clk);
		ex_instruction <= instr;
		ex_result <= result;
		ex_store_value <= value;
		ex_mask <= mask;
		ex_reg_lane_select <= lane;
		rb_squash_ma <= squash;
		ex_strand <= strand_sel;
		ex_pc <= ex_pc + 32'd4;
		ex_writeback_reg <= 5'd1;
		ex_enable_scalar_writeback <= 1'b1;
		ex_enable_vector_writeback <= 1'b1;
	endtask

	task automatic issue_scalar(input instruction_t instr, input logic [31:0] addr,
		input logic [31:0] value);
		issue(instr, VECTOR_BITS'(addr), VECTOR_BITS'(value), 4'hf, 2'd0, 1'b0);
	endtask

	// Idle slot, then sample the registered outputs mid-cycle
	task automatic wait_registered();
		@(posedge clk);
		ex_instruction <= instruction_t'(NOP);
		ex_mask <= '0;
		rb_squash_ma <= 1'b0;
		ex_enable_scalar_writeback <= 1'b0;
		ex_enable_vector_writeback <= 1'b0;
		@(negedge clk);
	endtask

	// Writeback fields registered from the unsquashed instruction one cycle earlier
	task automatic verify_writeback_fields(input instruction_t instr, input logic [31:0] pc,
		input logic [3:0] mask, input logic [1:0] lane, input logic [1:0] cache_lane);
		compare_instruction("ma_instruction", ma_instruction, instr);
		compare_bit("ma_enable_scalar_writeback", ma_enable_scalar_writeback, 1'b1);
		compare_bit("ma_enable_vector_writeback", ma_enable_vector_writeback, 1'b1);
		compare_word("ma_strand", 32'(ma_strand), 32'(strand_sel));
		compare_word("ma_pc", ma_pc, pc);
		compare_word("ma_writeback_reg", 32'(ma_writeback_reg), 32'd1);
		compare_word("ma_mask", 32'(ma_mask), 32'(mask));
		compare_word("ma_reg_lane_select", 32'(ma_reg_lane_select), 32'(lane));
		compare_word("ma_cache_lane_select", 32'(ma_cache_lane_select), 32'(cache_lane));
	endtask

	task automatic read_back(input logic [31:0] addr);
		issue_scalar(mem_op(1'b1, MEM_L, '0), addr, 32'h0);
		wait_registered();
		compare_bit("ma_was_load", ma_was_load, 1'b1);
		compare_line("load_line", load_line, expected_line(addr[7:4]));
	endtask

	task automatic scalar_stores();
		logic [31:0] value;
		for (int o = 0; o < 4; o++)
		begin
			value = $random(seed);
			issue_scalar(mem_op(1'b0, MEM_B, '0), 32'h20 + 32'(o), value);
			model_store(32'h20 + 32'(o), value, 1);
		end
		for (int o = 0; o < 4; o += 2)
		begin
			value = $random(seed);
			issue_scalar(mem_op(1'b0, MEM_S, '0), 32'h24 + 32'(o), value);
			model_store(32'h24 + 32'(o), value, 2);
		end
		value = $random(seed);
		issue_scalar(mem_op(1'b0, MEM_L, '0), 32'h28, value);
		model_store(32'h28, value, 4);
		read_back(32'h20);
	endtask

	task automatic block_stores();
		logic [VECTOR_BITS - 1:0] value;
		logic [3:0] mask;
		value = random_vector();
		issue(mem_op(1'b0, MEM_BLOCK, '0), VECTOR_BITS'(32'h40), value, 4'hf, 2'd0, 1'b0);
		model_block_store(32'h40, value, 4'hf);
		value = random_vector();
		mask = 4'($random(seed));
		if (mask == 4'h0 || mask == 4'hf)
			mask = 4'b0101;
		issue(mem_op(1'b0, MEM_BLOCK_M, '0), VECTOR_BITS'(32'h40), value, mask, 2'd0, 1'b0);
		model_block_store(32'h40, value, mask);
		read_back(32'h40);
	endtask

	task automatic scatter_gather();
		logic [VECTOR_BITS - 1:0] value;
		logic [VECTOR_BITS - 1:0] pointers;
		// Each lane points at a different line and word
		for (int k = 0; k < VECTOR_LANES; k++)
			pointers[32 * k +: 32] = 32'h60 + 32'(16 * k + 4 * k);
		value = random_vector();
		issue(mem_op(1'b0, MEM_SCGATH, '0), pointers, value, 4'hf, 2'd2, 1'b0);
		model_store(32'h88, value[64 +: 32], 4);
		value = random_vector();
		issue(mem_op(1'b0, MEM_SCGATH_M, '0), pointers, value, 4'b1101, 2'd1, 1'b0);
		@(negedge clk);
		verify_writeback_fields(mem_op(1'b0, MEM_SCGATH, '0), ex_pc - 32'd4, 4'hf, 2'd2, 2'd2);
		read_back(32'h88);
		read_back(32'h74);
	endtask

	task automatic expect_fault(input instruction_t instr, input logic [31:0] addr);
		issue_scalar(instr, addr, $random(seed));
		wait_registered();
		compare_bit("ma_alignment_fault", ma_alignment_fault, 1'b1);
		faults_expected++;
	endtask

	task automatic faults_and_squash();
		logic [31:0] value;
		value = $random(seed);
		issue_scalar(mem_op(1'b0, MEM_L, '0), 32'hA0, value);
		model_store(32'hA0, value, 4);
		value = $random(seed);
		issue_scalar(mem_op(1'b0, MEM_L, '0), 32'hA8, value);
		model_store(32'hA8, value, 4);
		expect_fault(mem_op(1'b0, MEM_S, '0), 32'hA1);
		expect_fault(mem_op(1'b0, MEM_L, '0), 32'hA2);
		expect_fault(mem_op(1'b0, MEM_BLOCK, '0), 32'hA4);
		expect_fault(mem_op(1'b0, MEM_B, '0), 32'hFFFF_0003);
		issue(mem_op(1'b0, MEM_L, '0), VECTOR_BITS'(32'hA4), random_vector(), 4'hf, 2'd0, 1'b1);
		wait_registered();
		compare_instruction("ma_instruction", ma_instruction, instruction_t'(NOP));
		compare_bit("ma_enable_scalar_writeback", ma_enable_scalar_writeback, 1'b0);
		compare_bit("ma_enable_vector_writeback", ma_enable_vector_writeback, 1'b0);
		compare_bit("ma_alignment_fault", ma_alignment_fault, 1'b0);
		// Squash keeps the sync flag and drops the fault of a misaligned access
		issue(mem_op(1'b1, MEM_SYNC, '0), VECTOR_BITS'(32'hA2), '0, 4'hf, 2'd0, 1'b1);
		@(negedge clk);
		compare_bit("dcache_req_sync", dcache_req_sync, 1'b1);
		wait_registered();
		compare_bit("ma_alignment_fault", ma_alignment_fault, 1'b0);
		compare_bit("dcache_req_sync", dcache_req_sync, 1'b0);
		read_back(32'hA0);
	endtask

	task automatic check_cache_pulses(input logic [3:0] exp);
		compare_bit("cache_flush", cache_flush, exp[CACHE_DFLUSH]);
		compare_bit("cache_stbar", cache_stbar, exp[CACHE_STBAR]);
		compare_bit("cache_dinvalidate", cache_dinvalidate, exp[CACHE_DINVALIDATE]);
		compare_bit("cache_iinvalidate", cache_iinvalidate, exp[CACHE_IINVALIDATE]);
	endtask

	task automatic control_and_io();
		logic [31:0] value;
		fmtd_op_t op;
		value = $random(seed);
		issue_scalar(mem_op(1'b0, MEM_CONTROL_REG, 25'(CR_SCRATCH2)), 32'h0, value);
		issue_scalar(mem_op(1'b1, MEM_CONTROL_REG, 25'(CR_SCRATCH2)), 32'h0, 32'h0);
		wait_registered();
		compare_word("ma_result", ma_result[31:0], value);
		strand_sel = 2'd3;
		issue_scalar(mem_op(1'b1, MEM_CONTROL_REG, 25'(CR_STRAND_ID)), 32'h0, 32'h0);
		wait_registered();
		compare_word("ma_result", ma_result[31:0], 32'd3);
		verify_writeback_fields(mem_op(1'b1, MEM_CONTROL_REG, 25'(CR_STRAND_ID)), ex_pc,
			4'hf, 2'd0, 2'd0);
		strand_sel = 2'd0;
		issue_scalar(mem_op(1'b1, MEM_CONTROL_REG, 25'(CR_FAULT_COUNT)), 32'h0, 32'h0);
		wait_registered();
		compare_word("ma_result", ma_result[31:0], 32'(faults_expected));
		// IO word register at the top of the address space
		value = $random(seed);
		issue_scalar(mem_op(1'b0, MEM_L, '0), 32'hFFFF_0008, value);
		issue_scalar(mem_op(1'b1, MEM_L, '0), 32'hFFFF_0008, 32'h0);
		wait_registered();
		compare_word("ma_io_response", ma_io_response, value);
		compare_bit("ma_was_io", ma_was_io, 1'b1);
		for (int i = 0; i < 4; i++)
		begin
			op = fmtd_op_t'(i);
			issue(cache_op(op), '0, '0, 4'h0, 2'd0, 1'b0);
			@(negedge clk);
			check_cache_pulses(4'b0001 << i);
			issue(cache_op(op), '0, '0, 4'h0, 2'd0, 1'b1);
			@(negedge clk);
			check_cache_pulses(4'b0000);
		end
		wait_registered();
	endtask

	// At most one of the line strobes and the flush or barrier pulses per cycle
	always @(negedge clk)
	begin
		if (!reset && $countones({i_memory_subsystem_top.dcache_req.load,
			i_memory_subsystem_top.dcache_req.store, cache_flush, cache_stbar}) > 1)
		begin
			$display("More than one of load, store, flush and store barrier active at %0t", $time);
			onehot_errors++;
		end
	end

	initial
	begin
		#(TEST_CYCLES * CLK_PERIOD_NS + MARGIN_NS);
		$display("Watchdog timeout: the tests did not finish in time");
		$display("Errors: %0d", error_count + onehot_errors);
		$display("=== FAIL ===");
		$finish;
	end

	initial
	begin
		seed = 32'hb6f;
		error_count = 0;
		onehot_errors = 0;
		faults_expected = 0;
		strand_sel = '0;
		for (int l = 0; l < MEM_LINES; l++)
		begin
			for (int o = 0; o < LINE_BYTES; o++)
				mem_model[l][o] = 8'h00;
		end
		reset = 1'b1;
		rb_squash_ma = 1'b0;
		ex_instruction = instruction_t'(NOP);
		ex_strand = '0;
		ex_store_value = '0;
		ex_writeback_reg = '0;
		ex_enable_scalar_writeback = 1'b0;
		ex_enable_vector_writeback = 1'b0;
		ex_pc = '0;
		ex_mask = '0;
		ex_result = '0;
		ex_reg_lane_select = '0;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		scalar_stores();
		block_stores();
		scatter_gather();
		faults_and_squash();
		control_and_io();
		$display("Errors: %0d (compare %0d, one-hot %0d)", error_count + onehot_errors,
			error_count, onehot_errors);
		if (error_count + onehot_errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- list.f
hw/mem_stage_pkg.sv
hw/dcache_req_if.sv
hw/memory_access_stage.sv
hw/control_regs.sv
hw/line_memory.sv
hw/io_scratch.sv
hw/memory_subsystem_top.sv
tb/tb_clock.sv
tb/memory_subsystem_tb.sv
